/* build.f */
+incdir+rtl
rtl/rv_pkg.sv
rtl/rv_stage_if.sv
rtl/rv_idu.sv
rtl/rv_exu.sv
rtl/rv_wbu.sv
rtl/rv_core.sv
testbench/tb_rv_core.sv

/* rtl/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// pc value loaded while rst_n is low
`define RV_RESET_PC 32'h8000_0000

// machine-mode CSR addresses handled by the core
`define RV_CSR_MTVEC    12'h305
`define RV_CSR_MSCRATCH 12'h340
`define RV_CSR_MEPC     12'h341
`define RV_CSR_MCAUSE   12'h342

// architectural integer registers, x0 included
`define RV_NREGS 32

`endif

/* rtl/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
	input  logic          clock,
	input  logic          rst_n,
	input  logic          inst_valid,
	input  rv_pkg::inst_u inst,
	output logic          busy,
	output logic [31:0]   pc,
	output logic          mem_wen,
	output logic [31:0]   mem_addr,
	output logic [31:0]   mem_wdata,
	output logic [3:0]    mem_wmask,
	input  logic [4:0]    dbg_addr,
	output logic [31:0]   dbg_data
);

	reg_read_if u_rd_if ();
	decode_if   u_dec_if (.clock(clock));
	result_if   u_res_if ();

	rv_idu u_idu (
		.clock      (clock),
		.rst_n      (rst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.pc         (pc),
		.busy       (busy),
		.rd_port    (u_rd_if.idu_mp),
		.dec        (u_dec_if.idu_mp)
	);

	rv_exu u_exu (
		.dec (u_dec_if.exu_mp),
		.res (u_res_if.exu_mp)
	);

	rv_wbu u_wbu (
		.clock     (clock),
		.rst_n     (rst_n),
		.res       (u_res_if.wbu_mp),
		.rd_port   (u_rd_if.wbu_mp),
		.pc        (pc),
		.mem_wen   (mem_wen),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wmask (mem_wmask),
		.dbg_addr  (dbg_addr),
		.dbg_data  (dbg_data)
	);

endmodule

/* rtl/rv_exu.sv */
`timescale 1ns/1ps

module rv_exu (
	decode_if.exu_mp dec,
	result_if.exu_mp res
);
	import rv_pkg::*;

	logic [31:0] lop;
	logic [31:0] rop;
	alu_op_e     alu_op;
	logic [32:0] alu_diff;
	logic        alu_less;
	logic [4:0]  shamt;
	logic [31:0] alu_val;
	logic [32:0] br_diff;
	logic        br_less;
	logic        br_taken;

	// stores reuse the adder for src1 + imm
	always_comb begin
		case (dec.opcode)
			OPC_LUI: begin
				lop = 32'b0;
				rop = dec.imm;
			end
			OPC_AUIPC: begin
				lop = dec.pc;
				rop = dec.imm;
			end
			OPC_JAL, OPC_JALR: begin
				lop = dec.pc;
				rop = 32'd4;
			end
			OPC_OPIMM, OPC_STORE: begin
				lop = dec.src1;
				rop = dec.imm;
			end
			OPC_OP: begin
				lop = dec.src1;
				rop = dec.src2;
			end
			default: begin
				lop = 32'b0;
				rop = 32'b0;
			end
		endcase
	end

	always_comb begin
		alu_op = ALU_ADD;
		if (dec.opcode == OPC_OP || dec.opcode == OPC_OPIMM) begin
			case (dec.funct3)
				3'b000: alu_op = (dec.itype == TYPE_R && dec.funct7[5]) ? ALU_SUB : ALU_ADD;
				3'b001: alu_op = ALU_SLL;
				3'b010: alu_op = ALU_LESS;
				3'b011: alu_op = ALU_ULESS;
				3'b100: alu_op = ALU_XOR;
				3'b101: alu_op = dec.funct7[5] ? ALU_SRA : ALU_SRL;
				3'b110: alu_op = ALU_OR;
				default: alu_op = ALU_AND;
			endcase
		end
	end

	// borrow out of the 33-bit subtract is the unsigned less-than
	assign alu_diff = {1'b0, lop} - {1'b0, rop};
	assign alu_less = (lop[31] & ~rop[31]) | (~(lop[31] ^ rop[31]) & alu_diff[31]);
	assign shamt    = rop[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD:   alu_val = lop + rop;
			ALU_SUB:   alu_val = alu_diff[31:0];
			ALU_AND:   alu_val = lop & rop;
			ALU_XOR:   alu_val = lop ^ rop;
			ALU_OR:    alu_val = lop | rop;
			ALU_SRL:   alu_val = lop >> shamt;
			ALU_SRA:   alu_val = $signed(lop) >>> shamt;
			ALU_SLL:   alu_val = lop << shamt;
			ALU_LESS:  alu_val = {31'b0, alu_less};
			default:   alu_val = {31'b0, alu_diff[32]};
		endcase
	end

	assign br_diff = {1'b0, dec.src1} - {1'b0, dec.src2};
	assign br_less = (dec.src1[31] & ~dec.src2[31])
		| (~(dec.src1[31] ^ dec.src2[31]) & br_diff[31]);

	always_comb begin
		case (dec.funct3)
			3'b000:  br_taken = ~|br_diff[31:0];
			3'b001:  br_taken = |br_diff[31:0];
			3'b100:  br_taken = br_less;
			3'b101:  br_taken = ~br_less;
			3'b110:  br_taken = br_diff[32];
			3'b111:  br_taken = ~br_diff[32];
			default: br_taken = 1'b0;
		endcase
	end

	assign res.jump_en = (dec.opcode == OPC_JAL) || (dec.opcode == OPC_JALR)
		|| (dec.opcode == OPC_BRANCH && br_taken);
	assign res.jump = (dec.opcode == OPC_JALR) ? ((dec.src1 + dec.imm) & ~32'd1)
		: (dec.pc + dec.imm);

	// ECALL and MRET are told apart by the funct12 field, which sits in imm
	always_comb begin
		case (dec.opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_OPIMM, OPC_OP: res.commit = CM_REG;
			OPC_STORE: res.commit = CM_STORE;
			OPC_SYSTEM: begin
				if (dec.funct3 == 3'b001 || dec.funct3 == 3'b010)
					res.commit = CM_CSR;
				else if (dec.funct3 == 3'b000 && dec.imm[11:0] == 12'h000)
					res.commit = CM_ECALL;
				else if (dec.funct3 == 3'b000 && dec.imm[11:0] == 12'h302)
					res.commit = CM_MRET;
				else
					res.commit = CM_NONE;
			end
			default: res.commit = CM_NONE;
		endcase
	end

	assign res.valid      = dec.valid;
	assign res.rd         = dec.rd;
	assign res.val        = (res.commit == CM_CSR) ? dec.csr_val : alu_val;
	assign res.csr_addr   = dec.imm[11:0];
	assign res.csr_wdata  = (dec.funct3 == 3'b010) ? (dec.src1 | dec.csr_val) : dec.src1;
	assign res.store_addr = alu_val;
	assign res.store_data = dec.src2;
	assign res.wmask      = (dec.funct3[1:0] == 2'b00) ? 4'h1 :
		(dec.funct3[1:0] == 2'b01) ? 4'h3 : 4'hf;

	// a taken redirect never points at an odd address
	assert property (@(posedge dec.clock) res.valid && res.jump_en |-> !res.jump[0])
		else $error("jump target has bit 0 set");

endmodule

/* rtl/rv_idu.sv */
`timescale 1ns/1ps

module rv_idu (
	input  logic          clock,
	input  logic          rst_n,
	input  logic          inst_valid,
	input  rv_pkg::inst_u inst,
	input  logic [31:0]   pc,
	output logic          busy,
	reg_read_if.idu_mp    rd_port,
	decode_if.idu_mp      dec
);
	import rv_pkg::*;

	inst_u       inst_q;
	logic [31:0] pc_q;
	logic        valid_q;
	inst_type_e  itype;

	// the held instruction lives for exactly one cycle, the one before commit
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= inst_valid && !valid_q;
		end
	end

	always_ff @(posedge clock) begin
		if (inst_valid && !valid_q) begin
			inst_q <= inst;
			pc_q   <= pc;
		end
	end

	assign busy = valid_q;

	always_comb begin
		case (opcode_e'(inst_q.r_fmt.opcode))
			OPC_LUI, OPC_AUIPC:             itype = TYPE_U;
			OPC_JAL:                        itype = TYPE_J;
			OPC_JALR, OPC_OPIMM, OPC_SYSTEM: itype = TYPE_I;
			OPC_BRANCH:                     itype = TYPE_B;
			OPC_STORE:                      itype = TYPE_S;
			default:                        itype = TYPE_R;
		endcase
	end

	// immediate bits are scattered differently in each layout
	always_comb begin
		case (itype)
			TYPE_I: dec.imm = {{20{inst_q.i_fmt.imm[11]}}, inst_q.i_fmt.imm};
			TYPE_S: dec.imm = {{20{inst_q.s_fmt.imm_hi[6]}}, inst_q.s_fmt.imm_hi,
				inst_q.s_fmt.imm_lo};
			TYPE_B: dec.imm = {{19{inst_q.b_fmt.imm12}}, inst_q.b_fmt.imm12,
				inst_q.b_fmt.imm11, inst_q.b_fmt.imm10_5, inst_q.b_fmt.imm4_1, 1'b0};
			TYPE_U: dec.imm = {inst_q.u_fmt.imm, 12'b0};
			TYPE_J: dec.imm = {{11{inst_q.j_fmt.imm20}}, inst_q.j_fmt.imm20,
				inst_q.j_fmt.imm19_12, inst_q.j_fmt.imm11, inst_q.j_fmt.imm10_1, 1'b0};
			default: dec.imm = 32'b0;
		endcase
	end

	assign rd_port.rs1_addr = inst_q.r_fmt.rs1;
	assign rd_port.rs2_addr = inst_q.r_fmt.rs2;
	assign rd_port.csr_addr = inst_q.i_fmt.imm;

	assign dec.valid   = valid_q;
	assign dec.opcode  = opcode_e'(inst_q.r_fmt.opcode);
	assign dec.itype   = itype;
	assign dec.funct3  = inst_q.r_fmt.funct3;
	assign dec.funct7  = inst_q.r_fmt.funct7;
	assign dec.rd      = inst_q.r_fmt.rd;
	assign dec.src1    = rd_port.rs1_data;
	assign dec.src2    = rd_port.rs2_data;
	assign dec.csr_val = rd_port.csr_data;
	assign dec.pc      = pc_q;

	// the fetch side must wait for busy to drop before the next word
	assert property (@(posedge clock) disable iff (!rst_n) busy |-> !inst_valid)
		else $error("inst_valid pulsed while an instruction is still in flight");

endmodule

/* rtl/rv_pkg.sv */
package rv_pkg;

	// one instruction word seen through each RV32I encoding layout
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
		struct packed {
			logic [6:0] imm_hi;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] imm_lo;
			logic [6:0] opcode;
		} s_fmt;
		struct packed {
			logic       imm12;
			logic [5:0] imm10_5;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [3:0] imm4_1;
			logic       imm11;
			logic [6:0] opcode;
		} b_fmt;
		struct packed {
			logic [19:0] imm;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} u_fmt;
		struct packed {
			logic       imm20;
			logic [9:0] imm10_1;
			logic       imm11;
			logic [7:0] imm19_12;
			logic [4:0] rd;
			logic [6:0] opcode;
		} j_fmt;
	} inst_u;

	typedef enum logic [2:0] {
		TYPE_R, TYPE_I, TYPE_S, TYPE_B, TYPE_U, TYPE_J
	} inst_type_e;

	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_OR,
		ALU_SRL, ALU_SRA, ALU_SLL, ALU_LESS, ALU_ULESS
	} alu_op_e;

	// kind of architectural update performed at commit
	typedef enum logic [2:0] {
		CM_NONE, CM_REG, CM_STORE, CM_CSR, CM_ECALL, CM_MRET
	} commit_e;

endpackage

/* rtl/rv_stage_if.sv */
`timescale 1ns/1ps

// operand reads from decode into the register and CSR state
interface reg_read_if;
	logic [4:0]  rs1_addr;
	logic [4:0]  rs2_addr;
	logic [11:0] csr_addr;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic [31:0] csr_data;

	modport idu_mp (output rs1_addr, rs2_addr, csr_addr, input rs1_data, rs2_data, csr_data);
	modport wbu_mp (input rs1_addr, rs2_addr, csr_addr, output rs1_data, rs2_data, csr_data);
endinterface

// the clock only serves checks in the purely combinational execute stage
interface decode_if (input logic clock);
	import rv_pkg::*;

	logic        valid;
	opcode_e     opcode;
	inst_type_e  itype;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [4:0]  rd;
	logic [31:0] imm;
	logic [31:0] src1;
	logic [31:0] src2;
	logic [31:0] csr_val;
	logic [31:0] pc;

	modport idu_mp (output valid, opcode, itype, funct3, funct7, rd, imm, src1, src2,
		csr_val, pc);
	modport exu_mp (input clock, valid, opcode, itype, funct3, funct7, rd, imm, src1, src2,
		csr_val, pc);
endinterface

interface result_if;
	import rv_pkg::*;

	logic        valid;
	commit_e     commit;
	logic [4:0]  rd;
	logic [31:0] val;
	logic        jump_en;
	logic [31:0] jump;
	logic [11:0] csr_addr;
	logic [31:0] csr_wdata;
	logic [31:0] store_addr;
	logic [31:0] store_data;
	logic [3:0]  wmask;

	modport exu_mp (output valid, commit, rd, val, jump_en, jump, csr_addr, csr_wdata,
		store_addr, store_data, wmask);
	modport wbu_mp (input valid, commit, rd, val, jump_en, jump, csr_addr, csr_wdata,
		store_addr, store_data, wmask);
endinterface

/* rtl/rv_wbu.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_wbu (
	input  logic        clock,
	input  logic        rst_n,
	result_if.wbu_mp    res,
	reg_read_if.wbu_mp  rd_port,
	output logic [31:0] pc,
	output logic        mem_wen,
	output logic [31:0] mem_addr,
	output logic [31:0] mem_wdata,
	output logic [3:0]  mem_wmask,
	input  logic [4:0]  dbg_addr,
	output logic [31:0] dbg_data
);
	import rv_pkg::*;

	// x0 has no storage
	logic [31:0] regs [1:`RV_NREGS-1];
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic [31:0] mcause;
	logic [31:0] mscratch;

	assign rd_port.rs1_data = (rd_port.rs1_addr == 5'd0) ? 32'b0 : regs[rd_port.rs1_addr];
	assign rd_port.rs2_data = (rd_port.rs2_addr == 5'd0) ? 32'b0 : regs[rd_port.rs2_addr];
	assign dbg_data         = (dbg_addr == 5'd0) ? 32'b0 : regs[dbg_addr];

	always_comb begin
		case (rd_port.csr_addr)
			`RV_CSR_MTVEC:    rd_port.csr_data = mtvec;
			`RV_CSR_MEPC:     rd_port.csr_data = mepc;
			`RV_CSR_MCAUSE:   rd_port.csr_data = mcause;
			`RV_CSR_MSCRATCH: rd_port.csr_data = mscratch;
			default:          rd_port.csr_data = 32'b0;
		endcase
	end

	// CSR commits carry the old CSR value in val, so rd sees it unchanged
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < `RV_NREGS; i++)
				regs[i] <= 32'b0;
		end else if (res.valid && (res.commit == CM_REG || res.commit == CM_CSR)
			&& res.rd != 5'd0) begin
			regs[res.rd] <= res.val;
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			pc       <= `RV_RESET_PC;
			mtvec    <= 32'b0;
			mepc     <= 32'b0;
			mcause   <= 32'b0;
			mscratch <= 32'b0;
		end else if (res.valid) begin
			case (res.commit)
				CM_ECALL: begin
					// pc still holds the address of the ECALL itself
					mepc   <= pc;
					mcause <= 32'd11;
					pc     <= mtvec;
				end
				CM_MRET: pc <= mepc;
				default: pc <= res.jump_en ? res.jump : pc + 32'd4;
			endcase
			if (res.commit == CM_CSR) begin
				case (res.csr_addr)
					`RV_CSR_MTVEC:    mtvec    <= res.csr_wdata;
					`RV_CSR_MEPC:     mepc     <= res.csr_wdata;
					`RV_CSR_MCAUSE:   mcause   <= res.csr_wdata;
					`RV_CSR_MSCRATCH: mscratch <= res.csr_wdata;
					default: ;
				endcase
			end
		end
	end

	// store strobe follows the commit edge by one cycle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			mem_wen <= 1'b0;
		end else begin
			mem_wen <= res.valid && res.commit == CM_STORE;
		end
	end

	always_ff @(posedge clock) begin
		if (res.valid && res.commit == CM_STORE) begin
			mem_addr  <= res.store_addr;
			mem_wdata <= res.store_data;
			mem_wmask <= res.wmask;
		end
	end

	// one instruction in flight means a store strobe can never last two cycles
	assert property (@(posedge clock) disable iff (!rst_n) mem_wen |=> !mem_wen)
		else $error("mem_wen held high for more than one cycle");

endmodule

/* testbench/tb_rv_core.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_rv_core;
	import rv_pkg::*;

	logic        clock;
	logic        rst_n;
	logic        inst_valid;
	inst_u       inst;
	logic        busy;
	logic [31:0] pc;
	logic        mem_wen;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wmask;
	logic [4:0]  dbg_addr;
	logic [31:0] dbg_data;

	// architectural state expected after each commit
	logic [31:0] model [0:`RV_NREGS-1];
	logic [31:0] exp_pc;
	int          errors;
	int          tests_pass;
	int          tests_fail;

	rv_core u_rv_core (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic inst_u enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		inst_u w;
		w.r_fmt = '{f7, rs2, rs1, f3, rd, opc};
		return w;
	endfunction

	function automatic inst_u enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		inst_u w;
		w.i_fmt = '{imm, rs1, f3, rd, opc};
		return w;
	endfunction

	function automatic inst_u enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		inst_u w;
		w.s_fmt = '{imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
		return w;
	endfunction

	function automatic inst_u enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		inst_u w;
		w.b_fmt = '{imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
		return w;
	endfunction

	function automatic inst_u enc_u(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
		inst_u w;
		w.u_fmt = '{imm, rd, opc};
		return w;
	endfunction

	function automatic inst_u enc_j(input logic [20:0] imm, input logic [4:0] rd);
		inst_u w;
		w.j_fmt = '{imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
		return w;
	endfunction

	// integer results as the ISA defines them for OP and OP-IMM
	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'b011: return (a < b) ? 32'd1 : 32'd0;
			3'b100: return a ^ b;
			3'b101: begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic br_ref(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("Fail time=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_mask(input string name, input logic [3:0] exp, input logic [3:0] act);
		if (act !== exp) begin
			errors++;
			$display("Fail time=%0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Fail time=%0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_reg(input logic [4:0] idx);
		@(posedge clock);
		#1;
		dbg_addr = idx;
		#1;
		check_word($sformatf("x%0d", idx), model[idx], dbg_data);
	endtask

	// one-cycle pulse, then wait for the commit that drops busy
	task automatic issue_inst(input inst_u word);
		int cycles;
		@(posedge clock);
		#1;
		inst = word;
		inst_valid = 1'b1;
		@(posedge clock);
		#1;
		inst_valid = 1'b0;
		cycles = 0;
		while (busy && cycles < 16) begin
			@(posedge clock);
			#1;
			cycles++;
		end
		if (busy) begin
			errors++;
			$display("Error at %0t: busy never fell after the instruction was issued", $time);
		end
	endtask

	task automatic run_inst(input inst_u word, input logic [31:0] next_pc);
		issue_inst(word);
		exp_pc = next_pc;
		check_word("pc", exp_pc, pc);
	endtask

	task automatic run_reg(input inst_u word, input logic [4:0] rd, input logic [31:0] val);
		run_inst(word, exp_pc + 32'd4);
		if (rd != 5'd0)
			model[rd] = val;
		check_reg(rd);
	endtask

	task automatic finish_test(input string name, input int start_errors);
		if (errors == start_errors) begin
			tests_pass++;
			$display("test %s: passed", name);
		end else begin
			tests_fail++;
			$display("test %s: failed with %0d errors", name, errors - start_errors);
		end
	endtask

	task automatic test_reset();
		int start;
		start = errors;
		check_word("pc", `RV_RESET_PC, pc);
		check_bit("busy", 1'b0, busy);
		check_bit("mem_wen", 1'b0, mem_wen);
		for (int r = 0; r < `RV_NREGS; r++)
			check_reg(5'(r));
		finish_test("reset", start);
	endtask

	task automatic test_arith();
		int          start;
		logic [31:0] a;
		logic [31:0] b;
		logic [11:0] imm;
		logic [2:0]  f3;
		logic        alt;
		start = errors;
		a = $urandom;
		b = $urandom;
		run_reg(enc_u(a[31:12], 5'd1, OPC_LUI), 5'd1, {a[31:12], 12'b0});
		run_reg(enc_i(a[11:0], 5'd1, 3'b000, 5'd1, OPC_OPIMM), 5'd1, model[1] + sext12(a[11:0]));
		run_reg(enc_u(b[31:12], 5'd2, OPC_LUI), 5'd2, {b[31:12], 12'b0});
		run_reg(enc_i(b[11:0], 5'd2, 3'b000, 5'd2, OPC_OPIMM), 5'd2, model[2] + sext12(b[11:0]));
		// the last two entries are SUB and SRA
		for (int k = 0; k < 10; k++) begin
			f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'b000 : 3'b101);
			alt = (k >= 8);
			run_reg(enc_r(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'(10 + k), OPC_OP), 5'(10 + k),
				alu_ref(f3, alt, model[1], model[2]));
		end
		for (int k = 0; k < 9; k++) begin
			f3 = (k < 8) ? 3'(k) : 3'b101;
			alt = (k == 8);
			imm = $urandom;
			if (f3 == 3'b001 || f3 == 3'b101)
				imm[11:5] = alt ? 7'h20 : 7'h00;
			run_reg(enc_i(imm, 5'd1, f3, 5'(20 + k), OPC_OPIMM), 5'(20 + k),
				alu_ref(f3, alt, model[1], sext12(imm)));
		end
		run_reg(enc_i(12'h005, 5'd1, 3'b000, 5'd0, OPC_OPIMM), 5'd0, 32'b0);
		finish_test("arith", start);
	endtask

	task automatic test_control();
		int          start;
		logic [12:0] boff;
		logic [20:0] joff;
		logic [11:0] imm;
		logic [4:0]  r1;
		logic [4:0]  r2;
		logic [31:0] target;
		start = errors;
		// x5 is negative signed but large unsigned against x6 and x7
		run_reg(enc_i(12'hfff, 5'd0, 3'b000, 5'd5, OPC_OPIMM), 5'd5, 32'hffff_ffff);
		run_reg(enc_i(12'h001, 5'd0, 3'b000, 5'd6, OPC_OPIMM), 5'd6, 32'd1);
		run_reg(enc_i(12'h001, 5'd0, 3'b000, 5'd7, OPC_OPIMM), 5'd7, 32'd1);
		for (int p = 0; p < 3; p++) begin
			r1 = (p == 0) ? 5'd5 : 5'd6;
			r2 = (p == 0) ? 5'd6 : ((p == 1) ? 5'd5 : 5'd7);
			for (int f = 0; f < 8; f++) begin
				if (f == 2 || f == 3)
					continue;
				boff = $urandom;
				boff[0] = 1'b0;
				target = br_ref(3'(f), model[r1], model[r2])
					? exp_pc + {{19{boff[12]}}, boff} : exp_pc + 32'd4;
				run_inst(enc_b(boff, r2, r1, 3'(f)), target);
			end
		end
		joff = $urandom;
		joff[0] = 1'b0;
		model[8] = exp_pc + 32'd4;
		run_inst(enc_j(joff, 5'd8), exp_pc + {{11{joff[20]}}, joff});
		check_reg(5'd8);
		// odd sum so that JALR has to clear bit 0
		imm = $urandom;
		imm[0] = ~model[1][0];
		model[9] = exp_pc + 32'd4;
		target = (model[1] + sext12(imm)) & ~32'd1;
		run_inst(enc_i(imm, 5'd1, 3'b000, 5'd9, OPC_JALR), target);
		check_reg(5'd9);
		finish_test("control", start);
	endtask

	task automatic test_store();
		int          start;
		logic [11:0] imm;
		start = errors;
		for (int k = 0; k < 3; k++) begin
			imm = $urandom;
			run_inst(enc_s(imm, 5'd2, 5'd1, 3'(k)), exp_pc + 32'd4);
			check_bit("mem_wen", 1'b1, mem_wen);
			check_word("mem_addr", model[1] + sext12(imm), mem_addr);
			check_word("mem_wdata", model[2], mem_wdata);
			check_mask("mem_wmask", (k == 0) ? 4'h1 : ((k == 1) ? 4'h3 : 4'hf), mem_wmask);
			@(posedge clock);
			#1;
			check_bit("mem_wen", 1'b0, mem_wen);
		end
		finish_test("store", start);
	endtask

	task automatic test_csr_trap();
		int          start;
		logic [31:0] a;
		logic [31:0] ecall_pc;
		start = errors;
		a = $urandom;
		// mscratch is still zero from reset
		run_reg(enc_i(`RV_CSR_MSCRATCH, 5'd1, 3'b001, 5'd10, OPC_SYSTEM), 5'd10, 32'b0);
		run_reg(enc_i(`RV_CSR_MSCRATCH, 5'd2, 3'b010, 5'd11, OPC_SYSTEM), 5'd11, model[1]);
		run_reg(enc_i(`RV_CSR_MSCRATCH, 5'd0, 3'b010, 5'd12, OPC_SYSTEM), 5'd12,
			model[1] | model[2]);
		run_reg(enc_u(a[31:12], 5'd13, OPC_LUI), 5'd13, {a[31:12], 12'b0});
		run_reg(enc_i(`RV_CSR_MTVEC, 5'd13, 3'b001, 5'd0, OPC_SYSTEM), 5'd0, 32'b0);
		ecall_pc = exp_pc;
		run_inst(enc_i(12'h000, 5'd0, 3'b000, 5'd0, OPC_SYSTEM), model[13]);
		run_reg(enc_i(`RV_CSR_MCAUSE, 5'd0, 3'b010, 5'd14, OPC_SYSTEM), 5'd14, 32'd11);
		run_reg(enc_i(`RV_CSR_MEPC, 5'd0, 3'b010, 5'd15, OPC_SYSTEM), 5'd15, ecall_pc);
		run_inst(enc_i(12'h302, 5'd0, 3'b000, 5'd0, OPC_SYSTEM), ecall_pc);
		finish_test("csr_trap", start);
	endtask

	task automatic test_unknown();
		int    start;
		inst_u w;
		start = errors;
		w = $urandom;
		w.r_fmt.opcode = 7'h0b;
		run_inst(w, exp_pc + 32'd4);
		check_bit("mem_wen", 1'b0, mem_wen);
		for (int r = 0; r < `RV_NREGS; r++)
			check_reg(5'(r));
		finish_test("unknown", start);
	endtask

	initial begin
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst = '0;
		dbg_addr = 5'd0;
		errors = 0;
		tests_pass = 0;
		tests_fail = 0;
		void'($urandom(53));
		for (int r = 0; r < `RV_NREGS; r++)
			model[r] = 32'b0;
		exp_pc = `RV_RESET_PC;
		repeat (10) @(posedge clock);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_arith();
		test_control();
		test_store();
		test_csr_trap();
		test_unknown();
		$display("tests passed: %0d, tests failed: %0d", tests_pass, tests_fail);
		if (errors == 0 && tests_fail == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
